// ==== Makefile ====
TOP = fibTb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f compile.f

clean:
	rm -rf obj_dir

// ==== compile.f ====
hw/fibPkg.sv
hw/fibCtrlIf.sv
hw/fibController.sv
hw/regFile.sv
hw/fibAlu.sv
hw/statusRegister.sv
hw/fibTop.sv
test/fibTop_properties.sv
test/fibTb.sv

// ==== hw/fibAlu.sv ====
`timescale 1ns/1ps

module fibAlu (
    fibCtrlIf.alu cmd,
    input  logic [fibPkg::dataWidth-1:0] operandA,
    input  logic [fibPkg::dataWidth-1:0] operandB,
    output logic [fibPkg::dataWidth-1:0] writeData,
    output logic carry,
    output logic zero,
    output logic negative
);

    // one extra bit keeps the carry out
    logic [fibPkg::dataWidth:0] sum;

    logic isAdd;

    assign isAdd = (cmd.aluOp == fibPkg::aluAdd);

    ////////////////////////////////////////
    // arithmetic
    ////////////////////////////////////////

    assign sum = {1'b0, operandA} + {1'b0, operandB};

    // load mode passes the seed straight to the write bus
    assign writeData = isAdd ? sum[fibPkg::dataWidth-1:0] : cmd.seedValue;

    ////////////////////////////////////////
    // flags
    ////////////////////////////////////////

    // carry only means something for an add
    assign carry = isAdd && sum[fibPkg::dataWidth];

    // zero and sign of whatever gets written
    assign zero     = (writeData == '0);
    assign negative = writeData[fibPkg::dataWidth-1];

endmodule

// ==== hw/fibController.sv ====
`timescale 1ns/1ps

module fibController (
    input  logic clk,
    input  logic arstN,
    input  logic start,
    input  logic lucasMode,
    input  logic [fibPkg::indexWidth-1:0] termIndex,
    output logic busy,
    output logic done,
    fibCtrlIf.ctrl cmd
);

    fibPkg::ctrlStateT state;
    fibPkg::ctrlStateT nextState;

    // index of the term being written in step
    logic [fibPkg::indexWidth-1:0] termCount;

    // request captured with an accepted start
    logic [fibPkg::indexWidth-1:0] savedIndex;
    logic savedLucas;

    // addresses of terms k-1 and k-2
    logic [fibPkg::indexWidth-1:0] prevOne;
    logic [fibPkg::indexWidth-1:0] prevTwo;

    logic accept;

    ////////////////////////////////////////
    // handshake
    ////////////////////////////////////////

    // start is ignored unless idle
    assign accept = start && (state == fibPkg::idle);

    assign busy = (state != fibPkg::idle);
    // finish lasts exactly one cycle
    assign done = (state == fibPkg::finish);

    // request latch, only loaded on accept
    always_ff @(posedge clk) begin
        if (accept) begin
            savedIndex <= termIndex;
            savedLucas <= lucasMode;
        end
    end

    ////////////////////////////////////////
    // state machine
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state     <= fibPkg::idle;
            termCount <= '0;
        end else begin
            state <= nextState;
            // first added term is term 2
            if (state == fibPkg::seed1) begin
                termCount <= 5'd2;
            end else if (state == fibPkg::step) begin
                termCount <= termCount + 5'd1;
            end
        end
    end

    always_comb begin
        nextState = state;
        unique case (state)
            fibPkg::idle: begin
                if (accept) begin
                    nextState = fibPkg::clear;
                end
            end
            fibPkg::clear: begin
                nextState = fibPkg::seed0;
            end
            fibPkg::seed0: begin
                // term 0 is the answer, skip the rest
                if (savedIndex == '0) begin
                    nextState = fibPkg::finish;
                end else begin
                    nextState = fibPkg::seed1;
                end
            end
            fibPkg::seed1: begin
                if (savedIndex == 5'd1) begin
                    nextState = fibPkg::finish;
                end else begin
                    nextState = fibPkg::step;
                end
            end
            fibPkg::step: begin
                // last add writes the requested term
                if (termCount == savedIndex) begin
                    nextState = fibPkg::finish;
                end
            end
            fibPkg::finish: begin
                nextState = fibPkg::idle;
            end
            default: begin
                nextState = fibPkg::idle;
            end
        endcase
    end

    ////////////////////////////////////////
    // datapath commands
    ////////////////////////////////////////

    assign prevOne = termCount - 5'd1;
    assign prevTwo = termCount - 5'd2;

    assign cmd.regClear = (state == fibPkg::clear);

    // one write per seed or step cycle
    assign cmd.writeEn = (state == fibPkg::seed0) || (state == fibPkg::seed1)
                      || (state == fibPkg::step);

    always_comb begin
        cmd.aluOp     = fibPkg::aluLoad;
        cmd.writeAddr = termCount[fibPkg::regAddrWidth-1:0];
        // seed1 and finish default to the second seed
        cmd.seedValue = 16'd1;
        if (state == fibPkg::seed0) begin
            cmd.writeAddr = '0;
            // lucas starts 2, 1 and fibonacci starts 0, 1
            cmd.seedValue = savedLucas ? 16'd2 : 16'd0;
        end else if (state == fibPkg::seed1) begin
            cmd.writeAddr = 4'd1;
        end else if (state == fibPkg::step) begin
            cmd.aluOp = fibPkg::aluAdd;
        end
    end

    // ring addressing, term k lives at k mod 16
    assign cmd.readAddrA = prevOne[fibPkg::regAddrWidth-1:0];
    assign cmd.readAddrB = prevTwo[fibPkg::regAddrWidth-1:0];

endmodule

// ==== hw/fibCtrlIf.sv ====
`timescale 1ns/1ps

interface fibCtrlIf;

    // sync wipe of the register file and sticky overflow
    logic regClear;

    // write strobe, register file and status capture
    logic writeEn;
    logic [fibPkg::regAddrWidth-1:0] writeAddr;

    // the two operand reads for an add
    logic [fibPkg::regAddrWidth-1:0] readAddrA;
    logic [fibPkg::regAddrWidth-1:0] readAddrB;

    // alu function and the constant for seed loads
    fibPkg::aluOpT aluOp;
    logic [fibPkg::dataWidth-1:0] seedValue;

    // controller side, drives everything
    modport ctrl (
        output regClear, writeEn, writeAddr, readAddrA, readAddrB, aluOp, seedValue
    );

    // register file side
    modport regs (
        input regClear, writeEn, writeAddr, readAddrA, readAddrB
    );

    // alu side
    modport alu (
        input aluOp, seedValue
    );

    // status register only needs clear and write strobe
    modport status (
        input regClear, writeEn
    );

endinterface

// ==== hw/fibPkg.sv ====
package fibPkg;

    ////////////////////////////////////////
    // datapath sizes
    ////////////////////////////////////////

    // one sequence term, also the bus width
    localparam int dataWidth = 16;

    // register file depth
    localparam int regCount = 16;

    // register index, log2 of regCount
    localparam int regAddrWidth = 4;

    // requested term index, 0 to 31
    localparam int indexWidth = 5;

    ////////////////////////////////////////
    // encodings
    ////////////////////////////////////////

    // alu operation select
    // load passes the seed, add sums the two read ports
    typedef enum logic {
        aluLoad = 1'b0,
        aluAdd  = 1'b1
    } aluOpT;

    // controller sequence
    // clear and seed0 always run, seed1 and step only for index 1 and up
    typedef enum logic [2:0] {
        idle   = 3'd0,
        clear  = 3'd1,
        seed0  = 3'd2,
        seed1  = 3'd3,
        step   = 3'd4,
        finish = 3'd5
    } ctrlStateT;

endpackage

// ==== hw/fibTop.sv ====
`timescale 1ns/1ps

module fibTop (
    input  logic clk,
    input  logic arstN,
    input  logic start,
    input  logic lucasMode,
    input  logic [4:0] termIndex,
    output logic busy,
    output logic done,
    output logic [15:0] result,
    output logic zero,
    output logic negative,
    output logic overflow
);

    ////////////////////////////////////////
    // internal nets
    ////////////////////////////////////////

    // controller command bundle
    fibCtrlIf ctrlBus ();

    // register file read ports into the alu
    logic [fibPkg::dataWidth-1:0] operandA;
    logic [fibPkg::dataWidth-1:0] operandB;

    // alu result bus and its flags
    logic [fibPkg::dataWidth-1:0] writeData;
    logic aluCarry;
    logic aluZero;
    logic aluNegative;

    ////////////////////////////////////////
    // blocks
    ////////////////////////////////////////

    fibController controller (
        .clk       (clk),
        .arstN     (arstN),
        .start     (start),
        .lucasMode (lucasMode),
        .termIndex (termIndex),
        .busy      (busy),
        .done      (done),
        .cmd       (ctrlBus.ctrl)
    );

    regFile registers (
        .clk       (clk),
        .arstN     (arstN),
        .cmd       (ctrlBus.regs),
        .writeData (writeData),
        .operandA  (operandA),
        .operandB  (operandB)
    );

    fibAlu alu (
        .cmd       (ctrlBus.alu),
        .operandA  (operandA),
        .operandB  (operandB),
        .writeData (writeData),
        .carry     (aluCarry),
        .zero      (aluZero),
        .negative  (aluNegative)
    );

    // held flags drive the top outputs
    statusRegister status (
        .clk            (clk),
        .arstN          (arstN),
        .cmd            (ctrlBus.status),
        .writeData      (writeData),
        .carry          (aluCarry),
        .zero           (aluZero),
        .negative       (aluNegative),
        .result         (result),
        .resultZero     (zero),
        .resultNegative (negative),
        .overflow       (overflow)
    );

endmodule

// ==== hw/regFile.sv ====
`timescale 1ns/1ps

module regFile (
    input  logic clk,
    input  logic arstN,
    fibCtrlIf.regs cmd,
    input  logic [fibPkg::dataWidth-1:0] writeData,
    output logic [fibPkg::dataWidth-1:0] operandA,
    output logic [fibPkg::dataWidth-1:0] operandB
);

    ////////////////////////////////////////
    // storage
    ////////////////////////////////////////

    logic [fibPkg::dataWidth-1:0] regs [fibPkg::regCount];

    // async wipe on reset, sync wipe at the start of every run
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < fibPkg::regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (cmd.regClear) begin
            for (int i = 0; i < fibPkg::regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (cmd.writeEn) begin
            regs[cmd.writeAddr] <= writeData;
        end
    end

    ////////////////////////////////////////
    // read ports
    ////////////////////////////////////////

    // combinational, same cycle as the address
    // no write bypass, the controller never reads the word it writes
    assign operandA = regs[cmd.readAddrA];
    assign operandB = regs[cmd.readAddrB];

endmodule

// ==== hw/statusRegister.sv ====
`timescale 1ns/1ps

module statusRegister (
    input  logic clk,
    input  logic arstN,
    fibCtrlIf.status cmd,
    input  logic [fibPkg::dataWidth-1:0] writeData,
    input  logic carry,
    input  logic zero,
    input  logic negative,
    output logic [fibPkg::dataWidth-1:0] result,
    output logic resultZero,
    output logic resultNegative,
    output logic overflow
);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            result         <= '0;
            resultZero     <= 1'b0;
            resultNegative <= 1'b0;
            overflow       <= 1'b0;
        end else begin
            // last written term and its flags
            if (cmd.writeEn) begin
                result         <= writeData;
                resultZero     <= zero;
                resultNegative <= negative;
            end
            // sticky across the run, dropped on the clear cycle
            if (cmd.regClear) begin
                overflow <= 1'b0;
            end else if (cmd.writeEn && carry) begin
                overflow <= 1'b1;
            end
        end
    end

endmodule

// ==== test/fibTb.sv ====
`timescale 1ns/1ps

module fibTb;

    ////////////////////////////////////////
    // timing
    ////////////////////////////////////////

    localparam int clkPeriod = 40;
    // longest run is index 31, done after 34 cycles
    localparam int runLimit = 40;
    // 64 sweep runs plus 20 random ones
    localparam int runCount = 84;
    localparam int watchdogNs = runCount * runLimit * clkPeriod + 20 * clkPeriod;

    logic clk;
    logic arstN;
    logic start;
    logic lucasMode;
    logic [4:0] termIndex;
    logic busy;
    logic done;
    logic [15:0] result;
    logic zero;
    logic negative;
    logic overflow;

    int errorCount = 0;

    fibTop fibTop_inst (.*);

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // hard stop if a run never finishes
    initial begin
        #(watchdogNs);
        $display("watchdog expired after %0t, a run never finished", $time);
        $display(">>> FAIL");
        $finish;
    end

    ////////////////////////////////////////
    // reference model, 32 bit so nothing wraps
    ////////////////////////////////////////

    function automatic logic [31:0] modelTerm(input int idx, input logic lucas);
        logic [31:0] older;
        logic [31:0] newer;
        logic [31:0] sum;
        older = lucas ? 32'd2 : 32'd0;
        newer = 32'd1;
        if (idx == 0) begin
            return older;
        end
        for (int k = 2; k <= idx; k++) begin
            sum = older + newer;
            older = newer;
            newer = sum;
        end
        return newer;
    endfunction

    // any term up to idx past 16 bits
    function automatic logic modelOverflow(input int idx, input logic lucas);
        logic seen = 1'b0;
        for (int k = 0; k <= idx; k++) begin
            if (modelTerm(k, lucas) > 32'hFFFF) begin
                seen = 1'b1;
            end
        end
        return seen;
    endfunction

    ////////////////////////////////////////
    // one request, called on a falling edge
    ////////////////////////////////////////

    task automatic runTerm(input logic [4:0] idx, input logic mode, input bit poke);
        logic [31:0] expTerm;
        logic expOverflow;
        int cycles;
        expTerm = modelTerm(int'(idx), mode);
        expOverflow = modelOverflow(int'(idx), mode);
        start = 1'b1;
        termIndex = idx;
        lucasMode = mode;
        @(negedge clk);
        // inputs move on, the captured request must not
        start = 1'b0;
        termIndex = ~idx;
        lucasMode = ~mode;
        cycles = 0;
        while (!done && cycles < runLimit) begin
            // second cycle of the run, start is ignored while busy
            start = poke && (cycles == 1);
            @(negedge clk);
            cycles++;
        end
        start = 1'b0;
        if (!done) begin
            $display("run for term %0d never raised done within %0d cycles", idx, runLimit);
            errorCount++;
        end else begin
            assert (result == expTerm[15:0]) else begin
                $display("[ERROR] %0t: term %0d lucas %0b result %0d expected %0d",
                         $time, idx, mode, result, expTerm[15:0]);
                errorCount++;
            end
            assert ((zero == (expTerm[15:0] == 16'd0)) && (negative == expTerm[15])) else begin
                $display("[ERROR] %0t: term %0d lucas %0b zero %0b negative %0b wrong",
                         $time, idx, mode, zero, negative);
                errorCount++;
            end
            assert (overflow == expOverflow) else begin
                $display("[ERROR] %0t: term %0d lucas %0b overflow %0b expected %0b",
                         $time, idx, mode, overflow, expOverflow);
                errorCount++;
            end
        end
        // back to idle before the next request
        @(negedge clk);
    endtask

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    initial begin
        int assertFails;
        void'($urandom(38618));
        arstN = 1'b0;
        start = 1'b0;
        lucasMode = 1'b0;
        termIndex = '0;
        repeat (5) @(negedge clk);
        arstN = 1'b1;
        @(negedge clk);
        assert (!busy && !done && (result == '0) && !overflow) else begin
            $display("[ERROR] %0t: outputs not cleared after reset", $time);
            errorCount++;
        end
        // every index in both modes, covers 24 and 25
        for (int m = 0; m < 2; m++) begin
            for (int i = 0; i < 32; i++) begin
                runTerm(5'(i), 1'(m), (m == 1) && (i == 20));
            end
        end
        repeat (20) begin
            runTerm(5'($urandom_range(31, 0)), 1'($urandom_range(1, 0)), 1'b0);
        end
        assertFails = fibTop_inst.fibTopChecks.failCount;
        $display("errors: %0d testbench, %0d assertion", errorCount, assertFails);
        if (errorCount == 0 && assertFails == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== test/fibTop_properties.sv ====
`timescale 1ns/1ps

module fibTopProperties (
    input logic clk,
    input logic arstN,
    input logic start,
    input logic busy,
    input logic done,
    input logic [15:0] result,
    input logic zero,
    input logic negative,
    input logic overflow,
    input fibPkg::ctrlStateT state
);

    // read by the testbench at the end of the run
    int failCount = 0;

    ////////////////////////////////////////
    // handshake
    ////////////////////////////////////////

    doneSinglePulse: assert property (@(posedge clk) disable iff (!arstN) done |=> !done)
        else begin
            $error("done stayed high for more than one cycle");
            failCount++;
        end

    doneOnlyWhenBusy: assert property (@(posedge clk) disable iff (!arstN) done |-> busy)
        else begin
            $error("done seen while busy was low");
            failCount++;
        end

    busyDropsAfterDone: assert property (@(posedge clk) disable iff (!arstN) done |=> !busy)
        else begin
            $error("busy still high the cycle after done");
            failCount++;
        end

    // an accepted start raises busy and opens the run with its clear cycle
    startEntersClear: assert property (@(posedge clk) disable iff (!arstN)
        (start && !busy) |=> busy && (state == fibPkg::clear))
        else begin
            $error("accepted start did not begin a run with the clear cycle");
            failCount++;
        end

    ////////////////////////////////////////
    // result and flags
    ////////////////////////////////////////

    flagsMatchResult: assert property (@(posedge clk) disable iff (!arstN)
        done |-> (zero == (result == '0)) && (negative == result[15]))
        else begin
            $error("zero or negative flag disagrees with result");
            failCount++;
        end

    // held from done until the next accepted start
    heldAfterDone: assert property (@(posedge clk) disable iff (!arstN)
        (done || !busy) |=> $stable({result, zero, negative, overflow}))
        else begin
            $error("result or flags changed while no run was in progress");
            failCount++;
        end

    // first edge after reset release
    cleanAfterReset: assert property (@(posedge clk)
        $rose(arstN) |-> !busy && !done && (result == '0) && !overflow)
        else begin
            $error("outputs not cleared after reset");
            failCount++;
        end

endmodule

bind fibTop fibTopProperties fibTopChecks (
    .clk      (clk),
    .arstN    (arstN),
    .start    (start),
    .busy     (busy),
    .done     (done),
    .result   (result),
    .zero     (zero),
    .negative (negative),
    .overflow (overflow),
    .state    (controller.state)
);
